//--- common/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define INSTR_WIDTH 32
`define FIFO_DEPTH 4

// only this word offset takes instructions
`define INSTR_ADDR 32'h0000_0000

`define AXI_RESP_OKAY 2'b00
`define AXI_RESP_SLVERR 2'b10

// 2R opcodes, instr[31:10]
`define EXE_TLBSRCH 22'h1920a
`define EXE_TLBRD 22'h1920b
`define EXE_TLBWR 22'h1920c
`define EXE_TLBFILL 22'h1920d
`define EXE_ERTN 22'h1920e
`define EXE_RDCNTIDV_W 22'h00018
`define EXE_RDCNTVH_W 22'h00019

`define EXE_TLBWR_OP 8'h51
`define EXE_TLBFILL_OP 8'h52
`define EXE_TLBRD_OP 8'h53
`define EXE_TLBSRCH_OP 8'h54
`define EXE_ERTN_OP 8'h55
`define EXE_RDCNTID_OP 8'h56
`define EXE_RDCNTVL_OP 8'h57
`define EXE_RDCNTVH_OP 8'h58

`define EXE_RES_CSR 3'b101

`endif

//--- common/core_pkg.sv
`include "core_defs.svh"

package core_pkg;

    typedef logic [`INSTR_WIDTH-1:0] instr_t;
    typedef logic [4:0] gpr_addr_t;
    typedef logic [7:0] alu_op_t;
    typedef logic [2:0] alu_sel_t;
    typedef logic [1:0] axil_resp_t;

    typedef struct packed {
        logic is_pri;
        logic need_refetch;
        logic redirect;
        logic not_commit_instr;
    } special_info_t;

    // 23 bits
    typedef struct packed {
        logic          legal;
        logic          reg_write_valid;
        gpr_addr_t     reg_write_addr;
        alu_op_t       aluop;
        alu_sel_t      alusel;
        logic          kernel_instr;
        special_info_t special_info;
    } decode_result_t;

    // write channels only
    typedef struct packed {
        logic [31:0] awaddr;
        logic        awvalid;
        instr_t      wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        axil_resp_t bresp;
        logic       bvalid;
    } axil_rsp_t;

    typedef enum logic {
        IDLE,
        RESP
    } resp_state_t;

endpackage

//--- hw/instr_axil_slave.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module instr_axil_slave
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  axil_req_t axil_req_i,
    output axil_rsp_t axil_rsp_o,
    input  logic      fifo_full_i,
    output logic      push_o,
    output instr_t    push_data_o
);

    resp_state_t state_q;
    axil_resp_t  bresp_q;
    logic        ready;
    logic        wr_fire;
    logic        wr_good;

    // address and data are taken together, only when there is room
    assign ready   = (state_q == IDLE) && !fifo_full_i && !reset_i;
    assign wr_fire = ready && axil_req_i.awvalid && axil_req_i.wvalid;
    assign wr_good = (axil_req_i.awaddr == `INSTR_ADDR) && (axil_req_i.wstrb == 4'hf);

    assign push_o      = wr_fire && wr_good;
    assign push_data_o = axil_req_i.wdata;

    always_comb begin
        axil_rsp_o         = '0;
        axil_rsp_o.awready = ready;
        axil_rsp_o.wready  = ready;
        axil_rsp_o.bresp   = bresp_q;
        axil_rsp_o.bvalid  = (state_q == RESP);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (wr_fire) begin
                        state_q <= RESP;
                    end
                end
                RESP: begin
                    if (axil_req_i.bready) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // response code held until the host takes it
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp_q <= wr_good ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
        end
    end

endmodule

//--- hw/instr_fifo.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module instr_fifo
    import core_pkg::*;
(
    input  logic   clk,
    input  logic   reset_i,
    input  logic   push_i,
    input  instr_t push_data_i,
    input  logic   pop_i,
    output instr_t head_o,
    output logic   full_o,
    output logic   empty_o
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

    instr_t             mem [`FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               push_en;
    logic               pop_en;

    assign push_en = push_i && !full_o;
    assign pop_en  = pop_i && !empty_o;

    assign full_o  = (count_q == CNT_W'(`FIFO_DEPTH));
    assign empty_o = (count_q == '0);
    assign head_o  = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (push_en) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_en) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (push_en && !pop_en) begin
                count_q <= count_q + 1'b1;
            end else if (pop_en && !push_en) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

//--- decoder/decoder_2r.sv
`timescale 1ns/1ps
`include "core_defs.svh"

// 2R format: {opcode[21:0], rj[4:0], rd[4:0]}
module decoder_2r
    import core_pkg::*;
(
    input  instr_t         instr_i,
    output decode_result_t result_o
);

    logic [21:0] opcode;
    gpr_addr_t   rj;
    gpr_addr_t   rd;

    assign opcode = instr_i[31:10];
    assign rj     = instr_i[9:5];
    assign rd     = instr_i[4:0];

    // privileged TLB and ERTN share the same flag set
    function automatic decode_result_t kernel_op(alu_op_t op);
        decode_result_t r;
        r                           = '0;
        r.legal                     = 1'b1;
        r.aluop                     = op;
        r.kernel_instr              = 1'b1;
        r.special_info.is_pri       = 1'b1;
        r.special_info.need_refetch = 1'b1;
        return r;
    endfunction

    // counter reads go through the CSR result path
    function automatic decode_result_t counter_op(alu_op_t op, gpr_addr_t dst);
        decode_result_t r;
        r                     = '0;
        r.legal               = 1'b1;
        r.reg_write_valid     = 1'b1;
        r.reg_write_addr      = dst;
        r.aluop               = op;
        r.alusel              = `EXE_RES_CSR;
        r.special_info.is_pri = 1'b1;
        return r;
    endfunction

    always_comb begin
        result_o = '0;
        case (opcode)
            `EXE_TLBWR:   result_o = kernel_op(`EXE_TLBWR_OP);
            `EXE_TLBFILL: result_o = kernel_op(`EXE_TLBFILL_OP);
            `EXE_TLBRD:   result_o = kernel_op(`EXE_TLBRD_OP);
            `EXE_TLBSRCH: result_o = kernel_op(`EXE_TLBSRCH_OP);
            `EXE_ERTN: begin
                result_o                               = kernel_op(`EXE_ERTN_OP);
                result_o.special_info.redirect         = 1'b1;
                result_o.special_info.not_commit_instr = 1'b1;
            end
            `EXE_RDCNTIDV_W: begin
                // rd==0 selects rdcntid, rj==0 selects rdcntvl
                result_o                     = counter_op(`EXE_RDCNTID_OP, rj);
                if (rd == '0) begin
                    result_o = counter_op(`EXE_RDCNTID_OP, rj);
                end else if (rj == '0) begin
                    result_o = counter_op(`EXE_RDCNTVL_OP, rd);
                end else begin
                    result_o.legal           = 1'b0;
                    result_o.reg_write_valid = 1'b0;
                end
            end
            `EXE_RDCNTVH_W: result_o = counter_op(`EXE_RDCNTVH_OP, rd);
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

//--- decoder/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import core_pkg::*;
(
    input  logic           clk,
    input  logic           reset_i,
    input  logic           fifo_empty_i,
    input  instr_t         fifo_head_i,
    output logic           pop_o,
    output logic           dec_valid_o,
    output decode_result_t dec_o,
    input  logic           dec_ready_i
);

    decode_result_t result;
    decode_result_t dec_q;
    logic           valid_q;
    logic           can_load;

    decoder_2r u_decoder (
        .instr_i  (fifo_head_i),
        .result_o (result)
    );

    // register is free, or its record leaves on this edge
    assign can_load = !valid_q || dec_ready_i;
    assign pop_o    = can_load && !fifo_empty_i;

    assign dec_valid_o = valid_q;
    assign dec_o       = dec_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (pop_o) begin
            valid_q <= 1'b1;
        end else if (dec_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            dec_q <= result;
        end
    end

endmodule

//--- hw/decode_top.sv
`timescale 1ns/1ps

module decode_top
    import core_pkg::*;
(
    input  logic           clk,
    input  logic           reset_i,
    input  axil_req_t      axil_req_i,
    output axil_rsp_t      axil_rsp_o,
    output logic           dec_valid_o,
    output decode_result_t dec_o,
    input  logic           dec_ready_i
);

    logic   push;
    instr_t push_data;
    logic   pop;
    instr_t head;
    logic   full;
    logic   empty;

    instr_axil_slave u_slave (
        .clk         (clk),
        .reset_i     (reset_i),
        .axil_req_i  (axil_req_i),
        .axil_rsp_o  (axil_rsp_o),
        .fifo_full_i (full),
        .push_o      (push),
        .push_data_o (push_data)
    );

    instr_fifo u_fifo (
        .clk         (clk),
        .reset_i     (reset_i),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .head_o      (head),
        .full_o      (full),
        .empty_o     (empty)
    );

    decode_stage u_stage (
        .clk          (clk),
        .reset_i      (reset_i),
        .fifo_empty_i (empty),
        .fifo_head_i  (head),
        .pop_o        (pop),
        .dec_valid_o  (dec_valid_o),
        .dec_o        (dec_o),
        .dec_ready_i  (dec_ready_i)
    );

endmodule

//--- tests/decode_sva.sv
`timescale 1ns/1ps

module decode_sva
    import core_pkg::*;
(
    input logic           clk,
    input logic           reset_i,
    input axil_req_t      axil_req_i,
    input axil_rsp_t      axil_rsp_o,
    input logic           dec_valid_o,
    input decode_result_t dec_o,
    input logic           dec_ready_i,
    input logic           fifo_full
);

    int fail_count = 0;

    // stalled record holds still
    a_dec_stable: assert property (@(posedge clk) disable iff (reset_i)
        dec_valid_o && !dec_ready_i |=> dec_valid_o && $stable(dec_o))
    else begin
        $error("dec_o changed while stalled");
        fail_count++;
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (reset_i)
        axil_rsp_o.bvalid && !axil_req_i.bready |=> axil_rsp_o.bvalid)
    else begin
        $error("bvalid dropped before bready");
        fail_count++;
    end

    a_no_accept_full: assert property (@(posedge clk) disable iff (reset_i)
        fifo_full |-> !axil_rsp_o.awready)
    else begin
        $error("awready high with FIFO full");
        fail_count++;
    end

endmodule

bind decode_top decode_sva u_sva (
    .clk         (clk),
    .reset_i     (reset_i),
    .axil_req_i  (axil_req_i),
    .axil_rsp_o  (axil_rsp_o),
    .dec_valid_o (dec_valid_o),
    .dec_o       (dec_o),
    .dec_ready_i (dec_ready_i),
    .fifo_full   (full)
);

//--- tests/decode_tb.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module decode_tb
    import core_pkg::*;
();

    logic           clk = 1'b0;
    logic           reset_i = 1'b1;
    logic [31:0]    awaddr = '0;
    logic           awvalid = 1'b0;
    instr_t         wdata = '0;
    logic [3:0]     wstrb = '0;
    logic           wvalid = 1'b0;
    logic           bready = 1'b0;
    logic           dec_ready = 1'b0;
    axil_req_t      axil_req;
    axil_rsp_t      axil_rsp;
    logic           dec_valid;
    decode_result_t dec;

    // one entry per stimulus line
    string          name_a[$];
    logic [31:0]    addr_a[$];
    logic [3:0]     strb_a[$];
    instr_t         word_a[$];
    axil_resp_t     resp_a[$];
    decode_result_t rec_a[$];
    decode_result_t mask_a[$];

    // records the DUT still owes, oldest first
    string          pend_name_q[$];
    decode_result_t pend_rec_q[$];
    decode_result_t pend_mask_q[$];

    int             n_lines = 0;
    int             write_errors = 0;
    int             record_errors = 0;
    logic [31:0]    rng = 32'hd5a1_4881;
    logic           held_valid = 1'b0;
    decode_result_t held_rec = '0;

    always_comb begin
        axil_req         = '0;
        axil_req.awaddr  = awaddr;
        axil_req.awvalid = awvalid;
        axil_req.wdata   = wdata;
        axil_req.wstrb   = wstrb;
        axil_req.wvalid  = wvalid;
        axil_req.bready  = bready;
    end

    decode_top dut0 (
        .clk         (clk),
        .reset_i     (reset_i),
        .axil_req_i  (axil_req),
        .axil_rsp_o  (axil_rsp),
        .dec_valid_o (dec_valid),
        .dec_o       (dec),
        .dec_ready_i (dec_ready)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // random stalls on both ready signals
    // output ready mostly low so the FIFO fills up
    always @(posedge clk) begin
        #1;
        rng       = xorshift32(rng);
        dec_ready = rng[3] & rng[4];
        bready    = rng[8] | rng[9];
    end

    task automatic load_stimulus();
        int          fd;
        int          cnt;
        string       line;
        string       name;
        logic [31:0] addr;
        logic [3:0]  strb;
        instr_t      word;
        axil_resp_t  resp;
        logic [22:0] rec;
        logic [22:0] mask;
        fd = $fopen("tests/decode_stimulus.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            cnt = $sscanf(line, "%s %h %h %h %h %h %h", name, addr, strb, word, resp, rec, mask);
            if (cnt != 7) begin
                $display("malformed stimulus line: %s", line);
                write_errors++;
            end else begin
                name_a.push_back(name);
                addr_a.push_back(addr);
                strb_a.push_back(strb);
                word_a.push_back(word);
                resp_a.push_back(resp);
                rec_a.push_back(rec);
                mask_a.push_back(mask);
            end
        end
        $fclose(fd);
        n_lines = name_a.size();
    endtask

    task automatic axi_write(input int idx);
        axil_resp_t got;
        if (resp_a[idx] == `AXI_RESP_OKAY) begin
            pend_name_q.push_back(name_a[idx]);
            pend_rec_q.push_back(rec_a[idx]);
            pend_mask_q.push_back(mask_a[idx]);
        end
        awaddr  = addr_a[idx];
        wstrb   = strb_a[idx];
        wdata   = word_a[idx];
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!(axil_rsp.awready && axil_rsp.wready)) @(negedge clk);
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        while (!(axil_rsp.bvalid && bready)) @(negedge clk);
        got = axil_rsp.bresp;
        @(posedge clk);
        #1;
        if (got !== resp_a[idx]) begin
            $display("[ERROR] %s: expected bresp %h, actual %h", name_a[idx], resp_a[idx], got);
            write_errors++;
        end
    endtask

    task automatic check_record();
        string          name;
        decode_result_t exp;
        decode_result_t mask;
        if (pend_rec_q.size() == 0) begin
            $display("output record %h appeared with no write pending", dec);
            record_errors++;
            return;
        end
        name = pend_name_q.pop_front();
        exp  = pend_rec_q.pop_front();
        mask = pend_mask_q.pop_front();
        if ((dec & mask) !== (exp & mask)) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp & mask, dec & mask);
            record_errors++;
        end
    endtask

    task automatic expect_low(input string sig, input logic value);
        if (value !== 1'b0) begin
            $display("[ERROR] reset: expected %s 0, actual %b", sig, value);
            record_errors++;
        end
    endtask

    // transfers are judged mid-cycle, the edge that follows completes them
    always @(negedge clk) begin
        if (reset_i) begin
            held_valid = 1'b0;
        end else begin
            if (held_valid && (!dec_valid || dec !== held_rec)) begin
                $display("output record changed or dropped while stalled");
                record_errors++;
            end
            if (dec_valid && dec_ready) begin
                check_record();
            end
            held_valid = dec_valid && !dec_ready;
            held_rec   = dec;
        end
    end

    task automatic run_all();
        repeat (4) @(posedge clk);
        #1;
        // reset state while reset is still held
        expect_low("awready", axil_rsp.awready);
        expect_low("wready", axil_rsp.wready);
        expect_low("bvalid", axil_rsp.bvalid);
        expect_low("dec_valid_o", dec_valid);
        reset_i = 1'b0;
        @(negedge clk);
        expect_low("bvalid", axil_rsp.bvalid);
        expect_low("dec_valid_o", dec_valid);
        @(posedge clk);
        #1;
        for (int i = 0; i < n_lines; i++) begin
            axi_write(i);
        end
        while (pend_rec_q.size() != 0) @(posedge clk);
        // late extra records would still show up here
        repeat (10) @(posedge clk);
    endtask

    initial begin
        load_stimulus();
        if (n_lines == 0) begin
            $display("no stimulus lines could be read");
            $display("ERRORS FOUND");
        end else begin
            run_all();
            $display("errors: %0d in writes, %0d in records, %0d in assertions",
                     write_errors, record_errors, dut0.u_sva.fail_count);
            if (write_errors + record_errors + dut0.u_sva.fail_count == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
        end
        $finish;
    end

    initial begin
        wait (n_lines > 0);
        repeat (n_lines * 40 + 200) @(posedge clk);
        $display("timeout after %0d cycles, DUT stopped responding", n_lines * 40 + 200);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- tests/decode_stimulus.txt
# name awaddr wstrb word bresp record mask, all hex except the name
# bresp 0 is OKAY and 2 is SLVERR; record bits are compared only where mask is set
tlbwr 00000000 f 06483000 0 40511c 7fffff
tlbfill 00000000 f 06483400 0 40521c 7fffff
tlbrd 00000000 f 06482c00 0 40531c 7fffff
tlbsrch 00000000 f 06482800 0 40541c 7fffff
ertn 00000000 f 06483800 0 40551f 7fffff
rdcntid 00000000 f 000060a0 0 6556a8 7fffff
rdcntvl 00000000 f 00006007 0 6757a8 7fffff
rdcnt_bad 00000000 f 00006064 0 000000 400000
rdcntvh 00000000 f 00006409 0 6958a8 7fffff
unknown 00000000 f 02800000 0 000000 7fffff
bad_addr 00000004 f 06483000 2 000000 000000
bad_strb 00000000 7 06483000 2 000000 000000
bp_tlbrd 00000000 f 06482c00 0 40531c 7fffff
bp_rdcntid 00000000 f 000063e0 0 7f56a8 7fffff
bp_ertn 00000000 f 06483800 0 40551f 7fffff
bp_rdcntvh 00000000 f 0000641f 0 7f58a8 7fffff
bp_rdcntvl 00000000 f 00006001 0 6157a8 7fffff
bp_strb0 00000000 0 06483400 2 000000 000000
bp_tlbfill 00000000 f 06483400 0 40521c 7fffff
bp_unknown 00000000 f ffffffff 0 000000 7fffff

//--- vlog.f
+incdir+common
common/core_pkg.sv
hw/instr_axil_slave.sv
hw/instr_fifo.sv
decoder/decoder_2r.sv
decoder/decode_stage.sv
hw/decode_top.sv
tests/decode_sva.sv
tests/decode_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the decode testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module decode_tb -Mdir obj_dir -o decode_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/decode_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
